/* hw/sdhc_config.svh */
`ifndef SDHC_CONFIG_SVH
`define SDHC_CONFIG_SVH

// bus geometry of the register port
`define SDHC_DATA_W 32
`define SDHC_ADDR_W 8
// word index, address with the two byte bits dropped
`define SDHC_IDX_W 6

// command field as it sits in xfer_cmd[29:16]
`define SDHC_CMD_W 14
// set_block_count with a short response, crc and index check
`define SDHC_CMD23_CODE 14'h171a
// card status expected back in response word 0 after cmd23
`define SDHC_CMD23_OK 16'h0900

// data timeout counter, 1 << (field + 13)
`define SDHC_TIMEOUT_W 29

// read-only identification words
`define SDHC_CAPS 32'h012c32b2
`define SDHC_VERSION 32'h00020000

`endif

/* hw/axil_pkg.sv */
`include "sdhc_config.svh"

package axil_pkg;

	// response codes, the port only ever returns okay
	typedef enum logic [1:0] {
		AXIL_OKAY   = 2'b00,
		AXIL_EXOKAY = 2'b01,
		AXIL_SLVERR = 2'b10,
		AXIL_DECERR = 2'b11
	} axil_resp_e;

	// everything the master drives: aw, w, ar and the two ready lines
	typedef struct packed {
		logic [`SDHC_ADDR_W-1:0]   awaddr;
		logic                      awvalid;
		logic [`SDHC_DATA_W-1:0]   wdata;
		logic [`SDHC_DATA_W/8-1:0] wstrb;
		logic                      wvalid;
		logic                      bready;
		logic [`SDHC_ADDR_W-1:0]   araddr;
		logic                      arvalid;
		logic                      rready;
	} axil_req_t;

	// everything the slave drives back
	typedef struct packed {
		logic                    awready;
		logic                    wready;
		logic                    bvalid;
		axil_resp_e              bresp;
		logic                    arready;
		logic                    rvalid;
		logic [`SDHC_DATA_W-1:0] rdata;
		axil_resp_e              rresp;
	} axil_rsp_t;

endpackage

/* hw/sdhc_pkg.sv */
`include "sdhc_config.svh"

package sdhc_pkg;

	// word index of each register, byte offset is index * 4
	typedef enum logic [`SDHC_IDX_W-1:0] {
		REG_ARG2      = 6'd0,
		REG_BLK       = 6'd1,
		REG_ARG1      = 6'd2,
		REG_XFER_CMD  = 6'd3,
		REG_RESP0     = 6'd4,
		REG_RESP1     = 6'd5,
		REG_RESP2     = 6'd6,
		REG_RESP3     = 6'd7,
		REG_HOST_CTRL = 6'd10,
		REG_CLK_CTRL  = 6'd11,
		REG_INT_STAT  = 6'd12,
		REG_INT_EN    = 6'd13,
		REG_INT_SIG   = 6'd14,
		REG_ACMD_ERR  = 6'd15,
		REG_CAPS      = 6'd16,
		REG_VERSION   = 6'd63
	} sdhc_reg_e;

	// auto cmd23 sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_CMD23,
		ST_SEND_CMD
	} acmd_state_e;

	// one register write, valid for a single cycle
	typedef struct packed {
		logic                      valid;
		sdhc_reg_e                 idx;
		logic [`SDHC_DATA_W-1:0]   data;
		logic [`SDHC_DATA_W/8-1:0] strb;
	} reg_wr_t;

	// command issued to the card-side engine
	typedef struct packed {
		logic                    start;
		logic [`SDHC_CMD_W-1:0]  cmd;
		logic [`SDHC_DATA_W-1:0] arg;
	} cmd_req_t;

	// command line event pulses
	typedef struct packed {
		logic complete;
		logic timeout_err;
		logic crc_err;
		logic end_err;
		logic index_err;
	} cmd_evt_t;

	// data line event pulses
	typedef struct packed {
		logic xfer_done;
		logic timeout_err;
		logic crc_err;
		logic end_err;
	} dat_evt_t;

	// transfer setup seen by the data path
	typedef struct packed {
		logic [11:0] blk_size;
		logic [15:0] blk_count;
		logic        dir;
		logic        width4;
		logic        width8;
	} xfer_cfg_t;

	// clock and reset setup seen by the card clock block
	typedef struct packed {
		logic [7:0]                 divisor;
		logic [`SDHC_TIMEOUT_W-1:0] timeout;
		logic [1:0]                 sw_rst;
	} clk_cfg_t;

endpackage

/* hw/axil_slave_port.sv */
`include "sdhc_config.svh"

module axil_slave_port
	import axil_pkg::*;
	import sdhc_pkg::*;
(
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  axil_req_t               bus_req_i,
	output axil_rsp_t               bus_rsp_o,
	output reg_wr_t                 wr_o,
	output sdhc_reg_e               rd_idx_o,
	output logic                    rd_en_o,
	input  logic [`SDHC_DATA_W-1:0] rd_data_i
);

	logic                    wr_ack;
	logic                    bvalid;
	logic                    arready;
	logic                    rvalid;
	logic [`SDHC_ADDR_W-1:0] awaddr;
	logic [`SDHC_ADDR_W-1:0] araddr;
	logic [`SDHC_DATA_W-1:0] rdata;
	logic                    aw_take;
	logic                    wr_take;
	logic                    ar_take;

	// a write needs both aw and w, and only one is in flight at a time
	assign aw_take = !wr_ack && !bvalid && bus_req_i.awvalid && bus_req_i.wvalid;
	// ready pulse seen with both valids still up, register updates here
	assign wr_take = wr_ack && bus_req_i.awvalid && bus_req_i.wvalid;
	// same rule on the read side, blocked until rdata is taken
	assign ar_take = !arready && !rvalid && bus_req_i.arvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ack  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			// aw and w ready share one pulse
			wr_ack  <= aw_take;
			arready <= ar_take;
			// response is raised on the update edge and held for bready
			if (wr_take)
				bvalid <= 1'b1;
			else if (bus_req_i.bready)
				bvalid <= 1'b0;
			if (rd_en_o)
				rvalid <= 1'b1;
			else if (bus_req_i.rready)
				rvalid <= 1'b0;
		end
	end

	// addresses and read data are payload only
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_take)
			awaddr <= bus_req_i.awaddr;
		if (ar_take)
			araddr <= bus_req_i.araddr;
		if (rd_en_o)
			rdata <= rd_data_i;
	end

	// write request, data and strobe are still held by the master
	assign wr_o.valid = wr_take;
	assign wr_o.idx   = sdhc_reg_e'(awaddr[`SDHC_IDX_W+1:2]);
	assign wr_o.data  = bus_req_i.wdata;
	assign wr_o.strb  = bus_req_i.wstrb;

	// read strobe on the edge that ends arready
	assign rd_en_o  = arready && bus_req_i.arvalid && !rvalid;
	assign rd_idx_o = sdhc_reg_e'(araddr[`SDHC_IDX_W+1:2]);

	assign bus_rsp_o.awready = wr_ack;
	assign bus_rsp_o.wready  = wr_ack;
	assign bus_rsp_o.bvalid  = bvalid;
	assign bus_rsp_o.bresp   = AXIL_OKAY;
	assign bus_rsp_o.arready = arready;
	assign bus_rsp_o.rvalid  = rvalid;
	assign bus_rsp_o.rdata   = rdata;
	assign bus_rsp_o.rresp   = AXIL_OKAY;

	// master may stall, the responses must not drop early
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		bvalid && !bus_req_i.bready |=> bvalid);
	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rvalid && !bus_req_i.rready |=> rvalid && $stable(rdata));

endmodule

/* hw/sdhc_regfile.sv */
`include "sdhc_config.svh"

module sdhc_regfile
	import sdhc_pkg::*;
(
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	input  reg_wr_t                       wr_i,
	input  sdhc_reg_e                     rd_idx_i,
	input  logic                          rd_en_i,
	output logic [`SDHC_DATA_W-1:0]       rd_data_o,
	input  logic [3:0][`SDHC_DATA_W-1:0]  resp_i,
	input  cmd_evt_t                      cmd_evt_i,
	input  dat_evt_t                      dat_evt_i,
	input  logic                          clk_stable_i,
	input  logic                          cc_mask_i,
	input  logic                          acmd_err_i,
	input  logic [7:0]                    acmd_err_stat_i,
	output logic                          sw_start_o,
	output logic [1:0]                    auto_cmd_o,
	output logic [`SDHC_CMD_W-1:0]        sw_cmd_o,
	output logic [`SDHC_DATA_W-1:0]       arg1_o,
	output logic [`SDHC_DATA_W-1:0]       arg2_o,
	output logic                          err_clr_o,
	output xfer_cfg_t                     xfer_cfg_o,
	output clk_cfg_t                      clk_cfg_o,
	output logic                          irq_o,
	output logic                          cmd_int_rst_o,
	output logic                          dat_int_rst_o
);

	logic [`SDHC_DATA_W-1:0] arg2_q;
	logic [`SDHC_DATA_W-1:0] blk_q;
	logic [`SDHC_DATA_W-1:0] arg1_q;
	logic [`SDHC_DATA_W-1:0] xfer_q;
	logic [`SDHC_DATA_W-1:0] host_q;
	logic [`SDHC_DATA_W-1:0] clk_q;
	logic [`SDHC_DATA_W-1:0] stat_q;
	logic [`SDHC_DATA_W-1:0] en_q;
	logic [`SDHC_DATA_W-1:0] sig_q;
	logic                    start_q;
	logic                    int_rst_q;
	logic [`SDHC_DATA_W-1:0] int_ev;
	logic [`SDHC_DATA_W-1:0] stat_clr;
	logic [`SDHC_DATA_W-1:0] rd_word;

	// replace only the strobed byte lanes
	function automatic logic [`SDHC_DATA_W-1:0] merge(input logic [`SDHC_DATA_W-1:0] old_val,
		input reg_wr_t wr);
		logic [`SDHC_DATA_W-1:0] res;
		res = old_val;
		for (int b = 0; b < `SDHC_DATA_W/8; b++)
		begin
			if (wr.strb[b])
				res[b*8 +: 8] = wr.data[b*8 +: 8];
		end
		return res;
	endfunction

	// event pulses mapped onto status bit positions
	always_comb
	begin
		int_ev     = '0;
		// cmd23 completion stays hidden from software
		int_ev[0]  = cmd_evt_i.complete && !cc_mask_i;
		int_ev[1]  = dat_evt_i.xfer_done;
		int_ev[16] = cmd_evt_i.timeout_err;
		int_ev[17] = cmd_evt_i.crc_err;
		int_ev[18] = cmd_evt_i.end_err;
		int_ev[19] = cmd_evt_i.index_err;
		int_ev[20] = dat_evt_i.timeout_err;
		int_ev[21] = dat_evt_i.crc_err;
		int_ev[22] = dat_evt_i.end_err;
		int_ev[24] = acmd_err_i;
	end

	// write one to clear, limited to strobed bytes
	assign stat_clr = (wr_i.valid && wr_i.idx == REG_INT_STAT) ? merge('0, wr_i) : '0;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arg2_q    <= '0;
			blk_q     <= '0;
			arg1_q    <= '0;
			xfer_q    <= '0;
			host_q    <= '0;
			clk_q     <= '0;
			stat_q    <= '0;
			en_q      <= '0;
			sig_q     <= '0;
			start_q   <= 1'b0;
			int_rst_q <= 1'b0;
		end
		else
		begin
			start_q   <= 1'b0;
			int_rst_q <= 1'b0;
			// software reset requests last a single cycle
			clk_q[26:24] <= 3'b000;
			// a new event wins over a clear in the same cycle
			stat_q <= (stat_q & ~stat_clr) | int_ev;
			if (wr_i.valid)
			begin
				case (wr_i.idx)
					REG_ARG2:      arg2_q <= merge(arg2_q, wr_i);
					REG_BLK:       blk_q <= merge(blk_q, wr_i);
					REG_ARG1:      arg1_q <= merge(arg1_q, wr_i);
					REG_HOST_CTRL: host_q <= merge(host_q, wr_i);
					REG_CLK_CTRL:  clk_q <= merge(clk_q, wr_i);
					REG_INT_EN:    en_q <= merge(en_q, wr_i);
					REG_INT_SIG:   sig_q <= merge(sig_q, wr_i);
					REG_INT_STAT:  int_rst_q <= 1'b1;
					REG_XFER_CMD:
					begin
						xfer_q <= merge(xfer_q, wr_i);
						// upper half write carries the command index, it starts the cmd
						start_q <= (wr_i.strb == 4'hC);
					end
					default: ;
				endcase
			end
		end
	end

	// sequencer side
	assign sw_start_o = start_q;
	assign auto_cmd_o = xfer_q[3:2];
	assign sw_cmd_o   = xfer_q[29:16];
	assign arg1_o     = arg1_q;
	assign arg2_o     = arg2_q;
	assign err_clr_o  = int_rst_q;

	// card side fields
	assign xfer_cfg_o.blk_size  = blk_q[11:0];
	assign xfer_cfg_o.blk_count = blk_q[31:16];
	assign xfer_cfg_o.dir       = xfer_q[4];
	assign xfer_cfg_o.width4    = host_q[1];
	assign xfer_cfg_o.width8    = host_q[5];
	assign clk_cfg_o.divisor    = clk_q[15:8] >> 1;
	assign clk_cfg_o.timeout    = (`SDHC_TIMEOUT_W'(1) << clk_q[19:16]) << 13;
	// all, then cmd line, then dat line
	assign clk_cfg_o.sw_rst     = clk_q[24] ? 2'b11 : (clk_q[25] ? 2'b01 :
		(clk_q[26] ? 2'b10 : 2'b00));

	assign irq_o         = |(stat_q & en_q & sig_q);
	assign cmd_int_rst_o = int_rst_q;
	assign dat_int_rst_o = int_rst_q;

	always_comb
	begin
		rd_word = '0;
		case (rd_idx_i)
			REG_ARG2:      rd_word = arg2_q;
			REG_BLK:       rd_word = blk_q;
			REG_ARG1:      rd_word = arg1_q;
			REG_XFER_CMD:  rd_word = xfer_q;
			REG_RESP0:     rd_word = resp_i[0];
			REG_RESP1:     rd_word = resp_i[1];
			REG_RESP2:     rd_word = resp_i[2];
			REG_RESP3:     rd_word = resp_i[3];
			REG_HOST_CTRL: rd_word = host_q;
			// bit 1 reports the live clock state
			REG_CLK_CTRL:  rd_word = {clk_q[31:2], clk_stable_i, clk_q[0]};
			// only enabled status is visible
			REG_INT_STAT:  rd_word = stat_q & en_q;
			REG_INT_EN:    rd_word = en_q;
			REG_INT_SIG:   rd_word = sig_q;
			REG_ACMD_ERR:  rd_word = {24'b0, acmd_err_stat_i};
			REG_CAPS:      rd_word = `SDHC_CAPS;
			REG_VERSION:   rd_word = `SDHC_VERSION;
			default:       rd_word = '0;
		endcase
	end

	// bus stays quiet outside the read strobe
	assign rd_data_o = rd_en_i ? rd_word : '0;

	// card clock block accepts one reset kind at a time
	a_sw_rst_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(clk_q[26:24]));

endmodule

/* hw/auto_cmd23_seq.sv */
`include "sdhc_config.svh"

module auto_cmd23_seq
	import sdhc_pkg::*;
(
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic                    sw_start_i,
	input  logic [1:0]              auto_cmd_i,
	input  logic [`SDHC_CMD_W-1:0]  sw_cmd_i,
	input  logic [`SDHC_DATA_W-1:0] arg1_i,
	input  logic [`SDHC_DATA_W-1:0] arg2_i,
	input  logic [`SDHC_DATA_W-1:0] resp0_i,
	input  cmd_evt_t                cmd_evt_i,
	input  logic                    err_clr_i,
	output cmd_req_t                cmd_req_o,
	output logic                    cc_mask_o,
	output logic                    acmd_err_o,
	output logic [7:0]              acmd_err_stat_o
);

	acmd_state_e state;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state           <= ST_IDLE;
			cmd_req_o       <= '0;
			cc_mask_o       <= 1'b0;
			acmd_err_o      <= 1'b0;
			acmd_err_stat_o <= '0;
		end
		else
		begin
			cmd_req_o.start <= 1'b0;
			acmd_err_o      <= 1'b0;
			if (err_clr_i)
				acmd_err_stat_o <= '0;
			case (state)
				ST_IDLE:
				begin
					if (sw_start_i && auto_cmd_i == 2'b10)
					begin
						// set block count goes out first, with arg2
						cmd_req_o <= '{start: 1'b1, cmd: `SDHC_CMD23_CODE, arg: arg2_i};
						cc_mask_o <= 1'b1;
						state     <= ST_WAIT_CMD23;
					end
					else if (sw_start_i)
						cmd_req_o <= '{start: 1'b1, cmd: sw_cmd_i, arg: arg1_i};
				end
				ST_WAIT_CMD23:
				begin
					if (cmd_evt_i.complete)
					begin
						cc_mask_o <= 1'b0;
						if (resp0_i[15:0] == `SDHC_CMD23_OK)
						begin
							// card took the count, now the real command
							cmd_req_o <= '{start: 1'b1, cmd: sw_cmd_i, arg: arg1_i};
							state     <= ST_SEND_CMD;
						end
						else
						begin
							// abort, the software command is never sent
							acmd_err_o      <= 1'b1;
							acmd_err_stat_o <= {3'b000, cmd_evt_i.index_err, cmd_evt_i.end_err,
								cmd_evt_i.crc_err, cmd_evt_i.timeout_err, 1'b0};
							state           <= ST_IDLE;
						end
					end
				end
				ST_SEND_CMD:
				begin
					// hand back once the second command is done
					if (cmd_evt_i.complete)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// software must not restart while cmd23 is outstanding
	a_no_start_in_wait: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		state == ST_WAIT_CMD23 |-> !sw_start_i);

endmodule

/* hw/sdhc_host_regs.sv */
`include "sdhc_config.svh"

module sdhc_host_regs
	import axil_pkg::*;
	import sdhc_pkg::*;
(
	input  logic                         S_AXI_ACLK,
	input  logic                         S_AXI_ARESETN,
	input  axil_req_t                    bus_req_i,
	output axil_rsp_t                    bus_rsp_o,
	input  logic [3:0][`SDHC_DATA_W-1:0] resp_i,
	input  cmd_evt_t                     cmd_evt_i,
	input  dat_evt_t                     dat_evt_i,
	input  logic                         clk_stable_i,
	output cmd_req_t                     cmd_req_o,
	output xfer_cfg_t                    xfer_cfg_o,
	output clk_cfg_t                     clk_cfg_o,
	output logic                         irq_o,
	output logic                         cmd_int_rst_o,
	output logic                         dat_int_rst_o
);

	// port to register file
	reg_wr_t                 wr;
	sdhc_reg_e               rd_idx;
	logic                    rd_en;
	logic [`SDHC_DATA_W-1:0] rd_data;
	// register file to sequencer and back
	logic                    sw_start;
	logic [1:0]              auto_cmd;
	logic [`SDHC_CMD_W-1:0]  sw_cmd;
	logic [`SDHC_DATA_W-1:0] arg1;
	logic [`SDHC_DATA_W-1:0] arg2;
	logic                    err_clr;
	logic                    cc_mask;
	logic                    acmd_err;
	logic [7:0]              acmd_err_stat;

	axil_slave_port u_port (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.bus_req_i     (bus_req_i),
		.bus_rsp_o     (bus_rsp_o),
		.wr_o          (wr),
		.rd_idx_o      (rd_idx),
		.rd_en_o       (rd_en),
		.rd_data_i     (rd_data)
	);

	sdhc_regfile u_regs (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.wr_i            (wr),
		.rd_idx_i        (rd_idx),
		.rd_en_i         (rd_en),
		.rd_data_o       (rd_data),
		.resp_i          (resp_i),
		.cmd_evt_i       (cmd_evt_i),
		.dat_evt_i       (dat_evt_i),
		.clk_stable_i    (clk_stable_i),
		.cc_mask_i       (cc_mask),
		.acmd_err_i      (acmd_err),
		.acmd_err_stat_i (acmd_err_stat),
		.sw_start_o      (sw_start),
		.auto_cmd_o      (auto_cmd),
		.sw_cmd_o        (sw_cmd),
		.arg1_o          (arg1),
		.arg2_o          (arg2),
		.err_clr_o       (err_clr),
		.xfer_cfg_o      (xfer_cfg_o),
		.clk_cfg_o       (clk_cfg_o),
		.irq_o           (irq_o),
		.cmd_int_rst_o   (cmd_int_rst_o),
		.dat_int_rst_o   (dat_int_rst_o)
	);

	// response word 0 carries the card status checked after cmd23
	auto_cmd23_seq u_acmd (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.sw_start_i      (sw_start),
		.auto_cmd_i      (auto_cmd),
		.sw_cmd_i        (sw_cmd),
		.arg1_i          (arg1),
		.arg2_i          (arg2),
		.resp0_i         (resp_i[0]),
		.cmd_evt_i       (cmd_evt_i),
		.err_clr_i       (err_clr),
		.cmd_req_o       (cmd_req_o),
		.cc_mask_o       (cc_mask),
		.acmd_err_o      (acmd_err),
		.acmd_err_stat_o (acmd_err_stat)
	);

endmodule

/* test/tb_sdhc_host_regs.sv */
`include "sdhc_config.svh"

module tb_sdhc_host_regs
	import axil_pkg::*;
	import sdhc_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	// one table row: op 1 writes, op 0 reads and compares
	typedef struct packed {
		logic        op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp;
	} stim_t;

	localparam logic [7:0] A_ARG2 = 8'h00;
	localparam logic [7:0] A_BLK = 8'h04;
	localparam logic [7:0] A_ARG1 = 8'h08;
	localparam logic [7:0] A_XFER = 8'h0C;
	localparam logic [7:0] A_HOST = 8'h28;
	localparam logic [7:0] A_CLK = 8'h2C;
	localparam logic [7:0] A_STAT = 8'h30;
	localparam logic [7:0] A_EN = 8'h34;
	localparam logic [7:0] A_SIG = 8'h38;
	localparam logic [7:0] A_AERR = 8'h3C;
	localparam int CARD_DLY = 20;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	axil_req_t               bus_req_i;
	axil_rsp_t               bus_rsp_o;
	logic [3:0][31:0]        resp_i;
	cmd_evt_t                cmd_evt_i;
	dat_evt_t                dat_evt_i;
	logic                    clk_stable_i;
	cmd_req_t                cmd_req_o;
	xfer_cfg_t               xfer_cfg_o;
	clk_cfg_t                clk_cfg_o;
	logic                    irq_o;
	logic                    cmd_int_rst_o;
	logic                    dat_int_rst_o;

	stim_t                   tbl[$];
	logic [31:0]             lcg_state = 32'h4f7e;
	logic [13:0]             cmd_log[$];
	logic [31:0]             arg_log[$];
	int                      cmpl_cnt = 0;
	int                      card_cnt = 0;
	logic                    card_crc = 1'b0;
	int                      rst_cnt = 0;
	logic [1:0]              rst_val = 2'b00;
	int                      cir_cnt = 0;
	int                      dir_cnt = 0;
	int                      cycles = 0;
	int                      limit = 1000000;

	sdhc_host_regs uut (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// run limit, set once the table length is known
	always @(posedge S_AXI_ACLK)
	begin
		cycles++;
		if (cycles >= limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

	// card model, logs each start and answers after a fixed delay
	always @(negedge S_AXI_ACLK)
	begin
		cmd_evt_i = '0;
		if (S_AXI_ARESETN && cmd_req_o.start)
		begin
			cmd_log.push_back(cmd_req_o.cmd);
			arg_log.push_back(cmd_req_o.arg);
			card_cnt = CARD_DLY;
		end
		else if (card_cnt > 0)
		begin
			card_cnt--;
			if (card_cnt == 0)
			begin
				cmd_evt_i.complete = 1'b1;
				cmd_evt_i.crc_err  = card_crc;
				cmpl_cnt++;
			end
		end
	end

	// pulse counters for the reset outputs
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			if (clk_cfg_o.sw_rst != 2'b00)
			begin
				rst_cnt++;
				rst_val = clk_cfg_o.sw_rst;
			end
			if (cmd_int_rst_o)
				cir_cnt++;
			if (dat_int_rst_o)
				dir_cnt++;
		end
	end

	function automatic logic [31:0] lcg();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int b = 0; b < 4; b++)
		begin
			if (strb[b])
				res[b*8 +: 8] = new_val[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic add_op(input logic op, input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [31:0] exp);
		tbl.push_back('{op: op, addr: addr, data: data, strb: strb, exp: exp});
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(negedge S_AXI_ACLK);
		bus_req_i.awaddr  = addr;
		bus_req_i.wdata   = data;
		bus_req_i.wstrb   = strb;
		bus_req_i.awvalid = 1'b1;
		bus_req_i.wvalid  = 1'b1;
		// aw and w are accepted together
		do
			@(negedge S_AXI_ACLK);
		while (!bus_rsp_o.awready);
		check_eq("bus_rsp_o.wready", bus_rsp_o.wready, 1);
		check_eq("bus_rsp_o.bvalid", bus_rsp_o.bvalid, 0);
		// response rises on the edge that ends the ready pulse
		@(negedge S_AXI_ACLK);
		check_eq("bus_rsp_o.awready", bus_rsp_o.awready, 0);
		check_eq("bus_rsp_o.bvalid", bus_rsp_o.bvalid, 1);
		check_eq("bus_rsp_o.bresp", bus_rsp_o.bresp, AXIL_OKAY);
		bus_req_i.awvalid = 1'b0;
		bus_req_i.wvalid  = 1'b0;
		// stall one cycle, bvalid has to hold
		@(negedge S_AXI_ACLK);
		check_eq("bus_rsp_o.bvalid", bus_rsp_o.bvalid, 1);
		bus_req_i.bready  = 1'b1;
		@(negedge S_AXI_ACLK);
		bus_req_i.bready  = 1'b0;
		check_eq("bus_rsp_o.bvalid", bus_rsp_o.bvalid, 0);
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge S_AXI_ACLK);
		bus_req_i.araddr  = addr;
		bus_req_i.arvalid = 1'b1;
		do
			@(negedge S_AXI_ACLK);
		while (!bus_rsp_o.arready);
		check_eq("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 0);
		// read data is latched on the edge that ends arready
		@(negedge S_AXI_ACLK);
		check_eq("bus_rsp_o.arready", bus_rsp_o.arready, 0);
		check_eq("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 1);
		check_eq("bus_rsp_o.rresp", bus_rsp_o.rresp, AXIL_OKAY);
		data = bus_rsp_o.rdata;
		bus_req_i.arvalid = 1'b0;
		// stall one cycle, rvalid and rdata have to hold
		@(negedge S_AXI_ACLK);
		check_eq("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 1);
		check_eq("bus_rsp_o.rdata", bus_rsp_o.rdata, data);
		bus_req_i.rready  = 1'b1;
		@(negedge S_AXI_ACLK);
		bus_req_i.rready  = 1'b0;
		check_eq("bus_rsp_o.rvalid", bus_rsp_o.rvalid, 0);
	endtask

	task automatic expect_read(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		bus_read(addr, rd);
		check_eq($sformatf("rdata@0x%02h", addr), rd, exp);
	endtask

	task automatic wait_completes(input int n);
		while (cmpl_cnt < n)
			@(negedge S_AXI_ACLK);
		repeat (3) @(negedge S_AXI_ACLK);
	endtask

	initial
	begin
		logic [31:0] w;
		logic [31:0] arg1_exp;
		logic [31:0] arg2_exp;
		logic [31:0] blk_exp;
		logic [31:0] host_exp;
		logic [31:0] a;
		logic [31:0] b;
		int base;
		bus_req_i     = '0;
		resp_i        = '0;
		resp_i[1]     = 32'h1111_2222;
		resp_i[2]     = 32'h3333_4444;
		resp_i[3]     = 32'h5555_6666;
		cmd_evt_i     = '0;
		dat_evt_i     = '0;
		clk_stable_i  = 1'b0;
		S_AXI_ARESETN = 1'b0;

		// reset values, then byte-merged writes of lcg words
		add_op(0, A_ARG2, 0, 0, 0);
		add_op(0, A_BLK, 0, 0, 0);
		add_op(0, A_ARG1, 0, 0, 0);
		add_op(0, A_XFER, 0, 0, 0);
		add_op(0, A_HOST, 0, 0, 0);
		add_op(0, A_CLK, 0, 0, 0);
		add_op(0, A_STAT, 0, 0, 0);
		add_op(0, A_EN, 0, 0, 0);
		add_op(0, A_SIG, 0, 0, 0);
		add_op(0, A_AERR, 0, 0, 0);
		add_op(0, 8'h10, 0, 0, 0);
		add_op(0, 8'h14, 0, 0, 32'h1111_2222);
		add_op(0, 8'h18, 0, 0, 32'h3333_4444);
		add_op(0, 8'h1C, 0, 0, 32'h5555_6666);
		add_op(0, 8'h40, 0, 0, `SDHC_CAPS);
		add_op(0, 8'hFC, 0, 0, `SDHC_VERSION);
		add_op(0, 8'h24, 0, 0, 0);
		arg1_exp = lcg();
		add_op(1, A_ARG1, arg1_exp, 4'hF, 0);
		add_op(0, A_ARG1, 0, 0, arg1_exp);
		w = lcg();
		arg1_exp = byte_merge(arg1_exp, w, 4'h5);
		add_op(1, A_ARG1, w, 4'h5, 0);
		add_op(0, A_ARG1, 0, 0, arg1_exp);
		w = lcg();
		arg2_exp = byte_merge('0, w, 4'hA);
		add_op(1, A_ARG2, w, 4'hA, 0);
		add_op(0, A_ARG2, 0, 0, arg2_exp);
		blk_exp = lcg();
		add_op(1, A_BLK, blk_exp, 4'hF, 0);
		w = lcg();
		blk_exp = byte_merge(blk_exp, w, 4'h3);
		add_op(1, A_BLK, w, 4'h3, 0);
		add_op(0, A_BLK, 0, 0, blk_exp);
		w = lcg();
		host_exp = byte_merge('0, w, 4'h1);
		add_op(1, A_HOST, w, 4'h1, 0);
		add_op(0, A_HOST, 0, 0, host_exp);
		limit = 20 * tbl.size() + 500;

		repeat (2) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		check_eq("irq_o", irq_o, 0);
		check_eq("cmd_req_o.start", cmd_req_o.start, 0);
		check_eq("clk_cfg_o.sw_rst", clk_cfg_o.sw_rst, 0);
		check_eq("cmd_int_rst_o", cmd_int_rst_o, 0);
		check_eq("dat_int_rst_o", dat_int_rst_o, 0);

		foreach (tbl[i])
		begin
			if (tbl[i].op)
				bus_write(tbl[i].addr, tbl[i].data, tbl[i].strb);
			else
				expect_read(tbl[i].addr, tbl[i].exp);
		end
		check_eq("xfer_cfg_o.blk_size", xfer_cfg_o.blk_size, blk_exp[11:0]);
		check_eq("xfer_cfg_o.blk_count", xfer_cfg_o.blk_count, blk_exp[31:16]);
		check_eq("xfer_cfg_o.width4", xfer_cfg_o.width4, host_exp[1]);
		check_eq("xfer_cfg_o.width8", xfer_cfg_o.width8, host_exp[5]);

		// divisor field 0x10, timeout field 2, full software reset
		clk_stable_i = 1'b1;
		bus_write(A_CLK, 32'h0102_1000, 4'hF);
		check_eq("clk_cfg_o.divisor", clk_cfg_o.divisor, 8'h08);
		check_eq("clk_cfg_o.timeout", clk_cfg_o.timeout, 32'h0000_8000);
		check_eq("sw_rst pulse count", rst_cnt, 1);
		check_eq("sw_rst value", rst_val, 2'b11);
		expect_read(A_CLK, 32'h0002_1002);

		// plain command
		bus_write(A_EN, 32'hFFFF_FFFF, 4'hF);
		a = lcg();
		bus_write(A_ARG1, a, 4'hF);
		bus_write(A_XFER, 32'h0C3A_0000, 4'hC);
		wait_completes(1);
		check_eq("start count", cmd_log.size(), 1);
		check_eq("cmd_req_o.cmd", cmd_log[0], 14'h0C3A);
		check_eq("cmd_req_o.arg", arg_log[0], a);
		expect_read(A_STAT, 32'h0000_0001);
		check_eq("irq_o", irq_o, 0);
		bus_write(A_SIG, 32'h0000_0001, 4'hF);
		check_eq("irq_o", irq_o, 1);
		bus_write(A_STAT, 32'h0000_0001, 4'hF);
		check_eq("irq_o", irq_o, 0);

		// auto cmd23 with a good card status, read direction
		resp_i[0] = 32'h0000_0900;
		b = lcg();
		a = lcg();
		bus_write(A_ARG2, b, 4'hF);
		bus_write(A_ARG1, a, 4'hF);
		bus_write(A_XFER, 32'h0000_0018, 4'h1);
		check_eq("xfer_cfg_o.dir", xfer_cfg_o.dir, 1);
		base = cmpl_cnt;
		bus_write(A_XFER, 32'h1234_0000, 4'hC);
		wait_completes(base + 1);
		expect_read(A_STAT, 32'h0000_0000);
		wait_completes(base + 2);
		check_eq("start count", cmd_log.size(), 3);
		check_eq("cmd_req_o.cmd", cmd_log[1], `SDHC_CMD23_CODE);
		check_eq("cmd_req_o.arg", arg_log[1], b);
		check_eq("cmd_req_o.cmd", cmd_log[2], 14'h1234);
		check_eq("cmd_req_o.arg", arg_log[2], a);
		expect_read(A_STAT, 32'h0000_0001);
		bus_write(A_STAT, 32'hFFFF_FFFF, 4'hF);

		// auto cmd23 rejected with a crc error, no second command
		resp_i[0] = 32'h0000_0B00;
		card_crc  = 1'b1;
		base = cmpl_cnt;
		bus_write(A_XFER, 32'h1234_0000, 4'hC);
		wait_completes(base + 1);
		repeat (CARD_DLY + 10) @(negedge S_AXI_ACLK);
		card_crc = 1'b0;
		check_eq("start count", cmd_log.size(), 4);
		check_eq("cmd_req_o.cmd", cmd_log[3], `SDHC_CMD23_CODE);
		expect_read(A_STAT, 32'h0102_0000);
		expect_read(A_AERR, 32'h0000_0004);
		bus_write(A_STAT, 32'hFFFF_FFFF, 4'hF);
		expect_read(A_STAT, 32'h0000_0000);
		expect_read(A_AERR, 32'h0000_0000);

		// data events and selective clear
		@(negedge S_AXI_ACLK);
		dat_evt_i = '{xfer_done: 1'b1, default: 1'b0};
		@(negedge S_AXI_ACLK);
		dat_evt_i = '{xfer_done: 1'b0, default: 1'b1};
		@(negedge S_AXI_ACLK);
		dat_evt_i = '0;
		expect_read(A_STAT, 32'h0070_0002);
		cir_cnt = 0;
		dir_cnt = 0;
		bus_write(A_STAT, 32'h0020_0002, 4'hF);
		repeat (2) @(negedge S_AXI_ACLK);
		check_eq("cmd_int_rst_o pulses", cir_cnt, 1);
		check_eq("dat_int_rst_o pulses", dir_cnt, 1);
		expect_read(A_STAT, 32'h0050_0000);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* build.f */
+incdir+hw
hw/axil_pkg.sv
hw/sdhc_pkg.sv
hw/axil_slave_port.sv
hw/sdhc_regfile.sv
hw/auto_cmd23_seq.sv
hw/sdhc_host_regs.sv
test/tb_sdhc_host_regs.sv

/* Bender.yml */
package:
  name: sdhc_host_regs

sources:
  - include_dirs:
      - hw
    files:
      - hw/axil_pkg.sv
      - hw/sdhc_pkg.sv
      - hw/axil_slave_port.sv
      - hw/sdhc_regfile.sv
      - hw/auto_cmd23_seq.sv
      - hw/sdhc_host_regs.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - test/tb_sdhc_host_regs.sv
